//--- src/psramPkg.sv
/*
 * Shared PSRAM controller types: opcode and sequencer enums, request and pin structs, register map
 */
package psramPkg;

	// --------------------------------------------------
	// Serial frame format
	// --------------------------------------------------
	// Opcode, address and one data word
	localparam int FRAME_BITS = 64;
	localparam int DATA_BITS  = 32;

	// PSRAM command opcodes
	typedef enum logic [7:0] {
		READ  = 8'h03,
		WRITE = 8'h02
	} psramOp_e;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		SCKLOW,
		SCKHIGH,
		FINISH
	} seqState_e;

	// Request as it goes out on MOSI, MSB first
	typedef struct packed {
		psramOp_e    opcode;
		logic [23:0] adrs;
		logic [31:0] wdata;
	} psramReq_t;

	// Pins driven by the controller
	typedef struct packed {
		logic sck;
		logic csN;
		logic mosi;
	} spiPins_t;

	// --------------------------------------------------
	// Register map, byte offsets
	// --------------------------------------------------
	localparam logic [4:0] REG_CTRL = 5'h00;
	localparam logic [4:0] REG_ADRS = 5'h04;
	localparam logic [4:0] REG_DATA = 5'h08;
	localparam logic [4:0] REG_CMD  = 5'h0C;
	localparam logic [4:0] REG_STAT = 5'h10;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- src/psramCkeGen.sv
/*
 * Divided clock-enable generator for the serial clock half-periods
 */
`timescale 1ns/1ps

module psramCkeGen (
	input  logic        sysClk,
	input  logic        rst,
	input  logic        run,
	input  logic [15:0] div,
	output logic        cke
);

	// Remaining system clocks in the current half-period
	logic [15:0] cnt;

	// --------------------------------------------------
	// Down counter
	// --------------------------------------------------
	// Held at div while idle, so the first pulse is div+1 clocks after run
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			cnt <= 16'd0;
		end
		else if (!run)
		begin
			cnt <= div;
		end
		else if (cnt == 16'd0)
		begin
			// Period done, start the next one
			cnt <= div;
		end
		else
		begin
			cnt <= cnt - 16'd1;
		end
	end

	// One cycle wide, only while a frame runs
	assign cke = run && (cnt == 16'd0);

endmodule

//--- src/psramSeqFsm.sv
/*
 * Frame sequencer: chip select, SCK phases, bit count, busy and done
 */
`timescale 1ns/1ps

module psramSeqFsm (
	input  logic sysClk,
	input  logic rst,
	input  logic start,
	input  logic cke,
	output logic run,
	output logic load,
	output logic shiftOut,
	output logic sampleIn,
	output logic sck,
	output logic csN,
	output logic busy,
	output logic done
);
	import psramPkg::*;

	seqState_e  state;
	// Falling SCK edges seen in this frame
	logic [6:0] bitCnt;
	logic       lastBit;
	// Pins come straight from flops
	logic       sckReg;
	logic       csNReg;

	assign lastBit = (bitCnt == 7'(FRAME_BITS - 1));

	// --------------------------------------------------
	// State register and pin flops
	// --------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			state  <= IDLE;
			bitCnt <= 7'd0;
			sckReg <= 1'b0;
			csNReg <= 1'b1;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// Select the device one clock after start
					if (start)
					begin
						state  <= LOAD;
						csNReg <= 1'b0;
					end
				end
				LOAD:
				begin
					state  <= SCKLOW;
					bitCnt <= 7'd0;
				end
				SCKLOW:
				begin
					// Rising edge, both sides sample
					if (cke)
					begin
						state  <= SCKHIGH;
						sckReg <= 1'b1;
					end
				end
				SCKHIGH:
				begin
					// Falling edge, next bit goes out
					if (cke)
					begin
						sckReg <= 1'b0;
						bitCnt <= bitCnt + 7'd1;
						state  <= lastBit ? FINISH : SCKLOW;
					end
				end
				FINISH:
				begin
					// Deselect one clock after the last fall
					csNReg <= 1'b1;
					state  <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// Decoded strobes
	// --------------------------------------------------
	// Timer runs only during the clocking states
	assign run      = (state == SCKLOW) || (state == SCKHIGH);
	assign load     = (state == LOAD);
	assign sampleIn = (state == SCKLOW) && cke;
	assign shiftOut = (state == SCKHIGH) && cke;
	assign busy     = (state != IDLE);
	assign done     = (state == FINISH);

	assign sck = sckReg;
	assign csN = csNReg;

endmodule

//--- src/psramShifter.sv
/*
 * Serial data path: 64-bit transmit shifter and 32-bit receive register
 */
`timescale 1ns/1ps

module psramShifter (
	input  logic                sysClk,
	input  logic                rst,
	input  psramPkg::psramReq_t req,
	input  logic                load,
	input  logic                shiftOut,
	input  logic                sampleIn,
	input  logic                miso,
	output logic                mosi,
	output logic [31:0]         rdata
);
	import psramPkg::*;

	// Opcode in the top byte, data word at the bottom
	logic [FRAME_BITS-1:0] txReg;
	// Keeps only the newest bits, the data phase at the end
	logic [DATA_BITS-1:0]  rxReg;

	// --------------------------------------------------
	// Transmit side
	// --------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			// MOSI idles low
			txReg <= '0;
		end
		else if (load)
		begin
			txReg <= req;
		end
		else if (shiftOut)
		begin
			// MSB first, zeros fill in behind
			txReg <= {txReg[FRAME_BITS-2:0], 1'b0};
		end
	end

	// Top bit is always on the line
	assign mosi = txReg[FRAME_BITS-1];

	// --------------------------------------------------
	// Receive side
	// --------------------------------------------------
	// Samples on every rising SCK, the opcode and address bits fall out the top
	always_ff @(posedge sysClk)
	begin
		if (sampleIn)
		begin
			rxReg <= {rxReg[DATA_BITS-2:0], miso};
		end
	end

	assign rdata = rxReg;

endmodule

//--- src/psramCsr.sv
/*
 * AXI4-Lite register file with control, address, data, command and status registers and the interrupt
 */
`timescale 1ns/1ps

module psramCsr (
	input  logic                sysClk,
	input  logic                rst,
	// AXI4-Lite slave
	input  logic [4:0]          s_awaddr,
	input  logic                s_awvalid,
	output logic                s_awready,
	input  logic [31:0]         s_wdata,
	input  logic [3:0]          s_wstrb,
	input  logic                s_wvalid,
	output logic                s_wready,
	output logic [1:0]          s_bresp,
	output logic                s_bvalid,
	input  logic                s_bready,
	input  logic [4:0]          s_araddr,
	input  logic                s_arvalid,
	output logic                s_arready,
	output logic [31:0]         s_rdata,
	output logic [1:0]          s_rresp,
	output logic                s_rvalid,
	input  logic                s_rready,
	// Sequencer and data path
	input  logic                busy,
	input  logic                done,
	input  logic [31:0]         rdata,
	output psramPkg::psramReq_t req,
	output logic                start,
	output logic [15:0]         div,
	output logic                irq
);
	import psramPkg::*;

	logic        wrAccept;
	logic        rdAccept;
	logic        wrErr;
	logic        opValid;
	psramOp_e    cmdOp;
	logic [31:0] wrOld;
	logic [31:0] wrNew;

	// Software visible state
	logic [15:0] divReg;
	logic        irqEn;
	logic [23:0] adrsReg;
	logic [31:0] dataReg;
	psramOp_e    opReg;
	logic        doneFlag;

	// Byte lanes with a strobe take the new data
	function automatic logic [31:0] mergeStrb(input logic [31:0] old, input logic [31:0] wd,
		input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++)
		begin
			if (strb[i])
			begin
				res[8*i +: 8] = wd[8*i +: 8];
			end
		end
		return res;
	endfunction

	// Register contents as seen by a read
	function automatic logic [31:0] regWord(input logic [4:0] addr);
		case (addr)
			REG_CTRL: return {15'd0, irqEn, divReg};
			REG_ADRS: return {8'd0, adrsReg};
			REG_DATA: return dataReg;
			REG_CMD:  return {24'd0, opReg};
			REG_STAT: return {30'd0, doneFlag, busy};
			default:  return 32'd0;
		endcase
	endfunction

	// --------------------------------------------------
	// Write channel
	// --------------------------------------------------
	// Address and data together with one response outstanding
	assign wrAccept  = s_awvalid && s_wvalid && !s_bvalid;
	assign s_awready = wrAccept;
	assign s_wready  = wrAccept;

	// Opcode sits in the low byte of a CMD write
	assign cmdOp   = psramOp_e'(s_wdata[7:0]);
	assign opValid = s_wstrb[0] && ((cmdOp == READ) || (cmdOp == WRITE));
	assign start   = wrAccept && (s_awaddr == REG_CMD) && opValid && !busy;

	always_comb
	begin
		wrOld = regWord(s_awaddr);
	end

	assign wrNew = mergeStrb(wrOld, s_wdata, s_wstrb);

	always_comb
	begin
		case (s_awaddr)
			REG_CTRL, REG_ADRS, REG_DATA, REG_STAT: wrErr = 1'b0;
			// Busy or unknown opcode is refused
			REG_CMD: wrErr = busy || !opValid;
			default: wrErr = 1'b1;
		endcase
	end

	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			divReg   <= 16'd0;
			irqEn    <= 1'b0;
			adrsReg  <= 24'd0;
			dataReg  <= 32'd0;
			opReg    <= READ;
			doneFlag <= 1'b0;
		end
		else
		begin
			if (wrAccept)
			begin
				case (s_awaddr)
					REG_CTRL: {irqEn, divReg} <= wrNew[16:0];
					REG_ADRS: adrsReg <= wrNew[23:0];
					REG_DATA: dataReg <= wrNew;
					default: ;
				endcase
			end
			if (start)
			begin
				opReg <= cmdOp;
			end
			// Read result replaces the word
			if (done && (opReg == READ))
			begin
				dataReg <= rdata;
			end
			// Sticky until the next frame starts
			if (start)
			begin
				doneFlag <= 1'b0;
			end
			else if (done)
			begin
				doneFlag <= 1'b1;
			end
		end
	end

	// Write response
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			s_bvalid <= 1'b0;
		end
		else if (wrAccept)
		begin
			s_bvalid <= 1'b1;
		end
		else if (s_bready)
		begin
			s_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge sysClk)
	begin
		if (wrAccept)
		begin
			s_bresp <= wrErr ? RESP_SLVERR : RESP_OKAY;
		end
	end

	// --------------------------------------------------
	// Read channel
	// --------------------------------------------------
	assign s_arready = !s_rvalid;
	assign rdAccept  = s_arvalid && !s_rvalid;

	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			s_rvalid <= 1'b0;
		end
		else if (rdAccept)
		begin
			s_rvalid <= 1'b1;
		end
		else if (s_rready)
		begin
			s_rvalid <= 1'b0;
		end
	end

	// Data held stable until taken
	always_ff @(posedge sysClk)
	begin
		if (rdAccept)
		begin
			s_rdata <= regWord(s_araddr);
			s_rresp <= (s_araddr inside {REG_CTRL, REG_ADRS, REG_DATA, REG_CMD, REG_STAT})
				? RESP_OKAY : RESP_SLVERR;
		end
	end

	// --------------------------------------------------
	// Outputs to the engine
	// --------------------------------------------------
	assign req.opcode = opReg;
	assign req.adrs   = adrsReg;
	assign req.wdata  = dataReg;
	assign div        = divReg;
	// Level interrupt
	assign irq        = doneFlag && irqEn;

endmodule

//--- src/psramUnit.sv
/*
 * PSRAM controller top: registers, timer, sequencer and shifter
 */
`timescale 1ns/1ps

module psramUnit (
	input  logic               sysClk,
	input  logic               rst,
	// AXI4-Lite slave
	input  logic [4:0]         s_awaddr,
	input  logic               s_awvalid,
	output logic               s_awready,
	input  logic [31:0]        s_wdata,
	input  logic [3:0]         s_wstrb,
	input  logic               s_wvalid,
	output logic               s_wready,
	output logic [1:0]         s_bresp,
	output logic               s_bvalid,
	input  logic               s_bready,
	input  logic [4:0]         s_araddr,
	input  logic               s_arvalid,
	output logic               s_arready,
	output logic [31:0]        s_rdata,
	output logic [1:0]         s_rresp,
	output logic               s_rvalid,
	input  logic               s_rready,
	// Serial pins
	output psramPkg::spiPins_t spi,
	input  logic               spiMiso,
	// Interrupt
	output logic               irq
);
	import psramPkg::*;

	psramReq_t   req;
	logic        start;
	logic [15:0] div;
	logic        run;
	logic        cke;
	logic        load;
	logic        shiftOut;
	logic        sampleIn;
	logic        sck;
	logic        csN;
	logic        mosi;
	logic        busy;
	logic        done;
	logic [31:0] rdata;

	// --------------------------------------------------
	// Register file
	// --------------------------------------------------
	psramCsr csr (
		.sysClk   (sysClk),
		.rst      (rst),
		.s_awaddr (s_awaddr),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.s_wdata  (s_wdata),
		.s_wstrb  (s_wstrb),
		.s_wvalid (s_wvalid),
		.s_wready (s_wready),
		.s_bresp  (s_bresp),
		.s_bvalid (s_bvalid),
		.s_bready (s_bready),
		.s_araddr (s_araddr),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata  (s_rdata),
		.s_rresp  (s_rresp),
		.s_rvalid (s_rvalid),
		.s_rready (s_rready),
		.busy     (busy),
		.done     (done),
		.rdata    (rdata),
		.req      (req),
		.start    (start),
		.div      (div),
		.irq      (irq)
	);

	// --------------------------------------------------
	// Serial engine
	// --------------------------------------------------
	// Half-period pacing
	psramCkeGen ckeGen (
		.sysClk(sysClk),
		.rst   (rst),
		.run   (run),
		.div   (div),
		.cke   (cke)
	);

	psramSeqFsm seqFsm (
		.sysClk  (sysClk),
		.rst     (rst),
		.start   (start),
		.cke     (cke),
		.run     (run),
		.load    (load),
		.shiftOut(shiftOut),
		.sampleIn(sampleIn),
		.sck     (sck),
		.csN     (csN),
		.busy    (busy),
		.done    (done)
	);

	psramShifter shifter (
		.sysClk  (sysClk),
		.rst     (rst),
		.req     (req),
		.load    (load),
		.shiftOut(shiftOut),
		.sampleIn(sampleIn),
		.miso    (spiMiso),
		.mosi    (mosi),
		.rdata   (rdata)
	);

	// Pin bundle
	assign spi.sck  = sck;
	assign spi.csN  = csN;
	assign spi.mosi = mosi;

endmodule

//--- verif/psramModel.sv
/*
 * SPI mode-0 PSRAM model: sparse word memory, fixed pattern for unwritten words
 */
`timescale 1ns/1ps

module psramModel (
	input  psramPkg::spiPins_t spi,
	output logic               miso
);
	import psramPkg::*;

	// Only written words are stored
	logic [31:0] mem [logic [23:0]];
	// Opcode, address and data as they arrive
	logic [63:0] frame;
	int          bitIdx;
	logic        reading;
	logic [31:0] rdWord;

	// Unwritten words depend on the full address
	function automatic logic [31:0] fetchWord(input logic [23:0] adrs);
		if (mem.exists(adrs))
			return mem[adrs];
		return {8'h00, adrs} ^ 32'h5a5a_0000;
	endfunction

	initial
	begin
		miso    = 1'b0;
		bitIdx  = 0;
		reading = 1'b0;
		frame   = '0;
		rdWord  = '0;
	end

	// New frame on select
	always @(negedge spi.csN)
	begin
		bitIdx  = 0;
		reading = 1'b0;
	end

	// --------------------------------------------------
	// Sample MOSI on the rising SCK
	// --------------------------------------------------
	always @(posedge spi.sck)
	begin
		if (!spi.csN)
		begin
			frame = {frame[62:0], spi.mosi};
			bitIdx++;
			// Opcode and address complete
			if (bitIdx == 32 && frame[31:24] == READ)
			begin
				reading = 1'b1;
				rdWord  = fetchWord(frame[23:0]);
			end
			// Commit only a full write frame
			if (bitIdx == 64 && frame[63:56] == WRITE)
				mem[frame[55:32]] = frame[31:0];
		end
	end

	// Read data changes on the falling SCK, MSB first
	always @(negedge spi.sck)
	begin
		if (!spi.csN && reading && bitIdx >= 32 && bitIdx < 64)
			miso = rdWord[63 - bitIdx];
	end

	always @(posedge spi.csN)
	begin
		miso = 1'b0;
	end

endmodule

//--- verif/psramUnit_assertions.sv
/*
 * Serial pin and AXI4-Lite response assertions, bound into psramUnit
 */
`timescale 1ns/1ps

module psramUnitAssertions (
	input logic sysClk,
	input logic rst,
	input logic sck,
	input logic csN,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready
);

	// Failures seen so far
	int failCnt = 0;

	// Pins idle one cycle into reset
	resetIdle: assert property (@(posedge sysClk) rst |=> (csN && !sck))
		else
		begin
			$error("serial pins not idle after reset");
			failCnt++;
		end

	// No clocking while deselected
	sckQuiet: assert property (@(posedge sysClk) disable iff (rst) csN |-> !sck)
		else
		begin
			$error("sck high while csN high");
			failCnt++;
		end

	// --------------------------------------------------
	// Responses hold until taken
	// --------------------------------------------------
	bHold: assert property (@(posedge sysClk) disable iff (rst) (bvalid && !bready) |=> bvalid)
		else
		begin
			$error("bvalid dropped before bready");
			failCnt++;
		end

	rHold: assert property (@(posedge sysClk) disable iff (rst) (rvalid && !rready) |=> rvalid)
		else
		begin
			$error("rvalid dropped before rready");
			failCnt++;
		end

endmodule

bind psramUnit psramUnitAssertions protoChk (
	.sysClk(sysClk),
	.rst   (rst),
	.sck   (spi.sck),
	.csN   (spi.csN),
	.bvalid(s_bvalid),
	.bready(s_bready),
	.rvalid(s_rvalid),
	.rready(s_rready)
);

//--- verif/psramUnitTb.sv
/*
 * Testbench for the PSRAM controller with clock, reset, AXI tasks, LFSR, reference and checker
 */
`timescale 1ns/1ps

module psramUnitTb;
	import psramPkg::*;

	// One captured read word
	typedef struct packed {
		logic [23:0] adrs;
		logic [31:0] got;
	} readObs_t;

	logic        sysClk;
	logic        rst;
	logic [4:0]  s_awaddr;
	logic        s_awvalid;
	logic        s_awready;
	logic [31:0] s_wdata;
	logic [3:0]  s_wstrb;
	logic        s_wvalid;
	logic        s_wready;
	logic [1:0]  s_bresp;
	logic        s_bvalid;
	logic        s_bready;
	logic [4:0]  s_araddr;
	logic        s_arvalid;
	logic        s_arready;
	logic [31:0] s_rdata;
	logic [1:0]  s_rresp;
	logic        s_rvalid;
	logic        s_rready;
	spiPins_t    spi;
	logic        spiMiso;
	logic        irq;

	logic [31:0] lfsrState;
	// Last word written per address
	logic [31:0] shadow [logic [23:0]];
	readObs_t    obsQ [$];
	int          cycleCnt;
	int          errCount;
	int          testErrBase;
	int          testsRun;
	int          testsFailed;

	psramUnit dut (.*);

	psramModel memModel (
		.spi (spi),
		.miso(spiMiso)
	);

	// 100 ns clock
	initial
	begin
		sysClk = 1'b0;
		forever #50 sysClk = ~sysClk;
	end

	always @(posedge sysClk)
		cycleCnt++;

	// --------------------------------------------------
	// Reference and random source
	// --------------------------------------------------
	// Last written word or the fill pattern
	function automatic logic [31:0] expectWord(input logic [23:0] adrs);
		if (shadow.exists(adrs))
			return shadow[adrs];
		return {8'h00, adrs} ^ 32'h5a5a_0000;
	endfunction

	// Right-shifting Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic takeBits(input int n, output logic [31:0] v);
		v = 32'd0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("mismatch %s: got %h, expected %h", name, got, exp);
		errCount++;
	endtask

	task automatic abortRun(input string reason);
		$display("error: %s", reason);
		$display("*** FAILED ***");
		$finish;
	endtask

	// Every captured read word against the reference
	always @(posedge sysClk)
	begin
		readObs_t obs;
		while (obsQ.size() != 0)
		begin
			obs = obsQ.pop_front();
			if (obs.got !== expectWord(obs.adrs))
				reportMismatch($sformatf("rdata[%h]", obs.adrs), obs.got,
					expectWord(obs.adrs));
		end
	end

	// --------------------------------------------------
	// AXI4-Lite master
	// --------------------------------------------------
	task automatic axiWrite(input logic [4:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int waitCnt;
		@(posedge sysClk);
		#1;
		s_awaddr  = addr;
		s_awvalid = 1'b1;
		s_wdata   = data;
		s_wstrb   = 4'hF;
		s_wvalid  = 1'b1;
		waitCnt   = 0;
		@(negedge sysClk);
		while (!(s_awready && s_wready))
		begin
			waitCnt++;
			if (waitCnt > 2000)
				abortRun("write was never accepted");
			@(negedge sysClk);
		end
		@(posedge sysClk);
		#1;
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
		waitCnt   = 0;
		@(negedge sysClk);
		while (!s_bvalid)
		begin
			waitCnt++;
			if (waitCnt > 2000)
				abortRun("no write response");
			@(negedge sysClk);
		end
		resp = s_bresp;
		// Response waits one cycle before it is taken
		@(posedge sysClk);
		#1;
		s_bready = 1'b1;
		@(posedge sysClk);
		#1;
		s_bready = 1'b0;
	endtask

	task automatic axiRead(input logic [4:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int waitCnt;
		@(posedge sysClk);
		#1;
		s_araddr  = addr;
		s_arvalid = 1'b1;
		waitCnt   = 0;
		@(negedge sysClk);
		while (!s_arready)
		begin
			waitCnt++;
			if (waitCnt > 2000)
				abortRun("read was never accepted");
			@(negedge sysClk);
		end
		@(posedge sysClk);
		#1;
		s_arvalid = 1'b0;
		waitCnt   = 0;
		@(negedge sysClk);
		while (!s_rvalid)
		begin
			waitCnt++;
			if (waitCnt > 2000)
				abortRun("no read data");
			@(negedge sysClk);
		end
		data = s_rdata;
		resp = s_rresp;
		// Read data waits one cycle before it is taken
		@(posedge sysClk);
		#1;
		s_rready = 1'b1;
		@(posedge sysClk);
		#1;
		s_rready = 1'b0;
	endtask

	// Poll status until done and not busy
	task automatic waitDone();
		logic [31:0] stat;
		logic [1:0]  resp;
		int          startCyc;
		startCyc = cycleCnt;
		axiRead(REG_STAT, stat, resp);
		while (stat !== 32'h2)
		begin
			if (cycleCnt - startCyc > 200000)
				abortRun("frame never reported done");
			axiRead(REG_STAT, stat, resp);
		end
	endtask

	// Full frame with the read word queued for the checker
	task automatic runFrame(input psramOp_e op, input logic [23:0] adrs,
		input logic [31:0] wdata);
		logic [1:0]  resp;
		logic [31:0] rd;
		readObs_t    obs;
		axiWrite(REG_ADRS, {8'h00, adrs}, resp);
		if (op == WRITE)
			axiWrite(REG_DATA, wdata, resp);
		axiWrite(REG_CMD, {24'h0, op}, resp);
		if (resp !== RESP_OKAY)
			reportMismatch("bresp CMD", resp, RESP_OKAY);
		waitDone();
		if (op == WRITE)
		begin
			shadow[adrs] = wdata;
		end
		else
		begin
			axiRead(REG_DATA, rd, resp);
			obs.adrs = adrs;
			obs.got  = rd;
			obsQ.push_back(obs);
		end
	endtask

	task automatic finishTest(input string name);
		// Let the checker drain
		@(posedge sysClk);
		#1;
		testsRun++;
		if (errCount == testErrBase)
		begin
			$display("test %s: ok", name);
		end
		else
		begin
			testsFailed++;
			$display("test %s: %0d errors", name, errCount - testErrBase);
		end
		testErrBase = errCount;
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic testReset();
		logic [31:0] rd;
		logic [1:0]  resp;
		axiRead(REG_STAT, rd, resp);
		if (rd !== 32'h0)
			reportMismatch("STAT", rd, 32'h0);
		if (irq !== 1'b0)
			reportMismatch("irq", irq, 1'b0);
		axiWrite(REG_CTRL, 32'h0001_00A5, resp);
		axiRead(REG_CTRL, rd, resp);
		if (rd !== 32'h0001_00A5)
			reportMismatch("CTRL", rd, 32'h0001_00A5);
		// Enabled but nothing done yet
		if (irq !== 1'b0)
			reportMismatch("irq", irq, 1'b0);
		axiWrite(REG_ADRS, 32'h00AB_CDEF, resp);
		axiRead(REG_ADRS, rd, resp);
		if (rd !== 32'h00AB_CDEF)
			reportMismatch("ADRS", rd, 32'h00AB_CDEF);
		axiWrite(REG_DATA, 32'h1234_5678, resp);
		axiRead(REG_DATA, rd, resp);
		if (rd !== 32'h1234_5678)
			reportMismatch("DATA", rd, 32'h1234_5678);
		if (resp !== RESP_OKAY)
			reportMismatch("rresp DATA", resp, RESP_OKAY);
		axiWrite(REG_CTRL, 32'h0, resp);
		finishTest("1 reset and readback");
	endtask

	task automatic testMemory();
		logic [1:0]  resp;
		logic [31:0] a;
		logic [31:0] d;
		logic [23:0] wrList [$];
		axiWrite(REG_CTRL, 32'h1, resp);
		for (int i = 0; i < 20; i++)
		begin
			takeBits(24, a);
			takeBits(32, d);
			runFrame(WRITE, a[23:0], d);
			wrList.push_back(a[23:0]);
			// Older written word
			if (i % 2 == 1)
				runFrame(READ, wrList[i / 2], 32'h0);
			// Most likely never written
			if (i % 4 == 3)
			begin
				takeBits(24, a);
				runFrame(READ, a[23:0], 32'h0);
			end
		end
		runFrame(READ, wrList[19], 32'h0);
		finishTest("2 memory traffic");
	endtask

	// Clocks between rising SCK edges as seen on the falling system clock
	task automatic measureSck(input logic [15:0] divVal);
		logic [1:0]  resp;
		logic [31:0] rd;
		logic        prevSck;
		int          riseCyc [3];
		int          nRise;
		int          waitCnt;
		readObs_t    obs;
		axiWrite(REG_CTRL, {16'h0, divVal}, resp);
		axiWrite(REG_ADRS, 32'h0000_0100 + divVal, resp);
		axiWrite(REG_CMD, {24'h0, READ}, resp);
		nRise   = 0;
		waitCnt = 0;
		@(negedge sysClk);
		prevSck = spi.sck;
		while (nRise < 3)
		begin
			waitCnt++;
			if (waitCnt > 2000)
				abortRun("serial clock stopped");
			@(negedge sysClk);
			if (spi.sck && !prevSck)
			begin
				riseCyc[nRise] = cycleCnt;
				nRise++;
			end
			prevSck = spi.sck;
		end
		for (int i = 1; i < 3; i++)
		begin
			if (riseCyc[i] - riseCyc[i - 1] != 2 * (divVal + 1))
				reportMismatch($sformatf("sck period div %0d", divVal),
					riseCyc[i] - riseCyc[i - 1], 2 * (divVal + 1));
		end
		waitDone();
		axiRead(REG_DATA, rd, resp);
		obs.adrs = 24'h000100 + divVal;
		obs.got  = rd;
		obsQ.push_back(obs);
	endtask

	task automatic testDivider();
		measureSck(16'd0);
		measureSck(16'd3);
		measureSck(16'd9);
		finishTest("3 divider");
	endtask

	task automatic testErrors();
		logic [1:0]  resp;
		logic [31:0] rd;
		logic [31:0] adrsA;
		logic [31:0] dataA;
		logic [31:0] adrsB;
		logic [31:0] adrsC;
		// Unmapped offsets
		axiWrite(5'h14, 32'h1, resp);
		if (resp !== RESP_SLVERR)
			reportMismatch("bresp unmapped", resp, RESP_SLVERR);
		axiRead(5'h1C, rd, resp);
		if (resp !== RESP_SLVERR)
			reportMismatch("rresp unmapped", resp, RESP_SLVERR);
		// Command while a frame runs
		takeBits(24, adrsA);
		takeBits(32, dataA);
		takeBits(24, adrsB);
		axiWrite(REG_CTRL, 32'h3, resp);
		axiWrite(REG_ADRS, adrsA, resp);
		axiWrite(REG_DATA, dataA, resp);
		axiWrite(REG_CMD, {24'h0, WRITE}, resp);
		axiWrite(REG_ADRS, adrsB, resp);
		axiWrite(REG_CMD, {24'h0, WRITE}, resp);
		if (resp !== RESP_SLVERR)
			reportMismatch("bresp CMD busy", resp, RESP_SLVERR);
		waitDone();
		shadow[adrsA[23:0]] = dataA;
		runFrame(READ, adrsA[23:0], 32'h0);
		runFrame(READ, adrsB[23:0], 32'h0);
		// Unknown opcode
		takeBits(24, adrsC);
		axiWrite(REG_ADRS, adrsC, resp);
		axiWrite(REG_DATA, 32'hDEAD_BEEF, resp);
		axiWrite(REG_CMD, 32'h0000_009F, resp);
		if (resp !== RESP_SLVERR)
			reportMismatch("bresp CMD opcode", resp, RESP_SLVERR);
		axiRead(REG_STAT, rd, resp);
		if (rd !== 32'h2)
			reportMismatch("STAT", rd, 32'h2);
		runFrame(READ, adrsC[23:0], 32'h0);
		finishTest("4 error responses");
	endtask

	task automatic testIrq();
		logic [1:0]  resp;
		logic [31:0] rd;
		readObs_t    obs;
		axiWrite(REG_CTRL, 32'h0000_0001, resp);
		runFrame(WRITE, 24'h00_0040, 32'hC0DE_0040);
		// Done but disabled
		if (irq !== 1'b0)
			reportMismatch("irq", irq, 1'b0);
		axiWrite(REG_CTRL, 32'h0001_0001, resp);
		if (irq !== 1'b1)
			reportMismatch("irq", irq, 1'b1);
		// Next start clears done and irq
		axiWrite(REG_ADRS, 32'h0000_0040, resp);
		axiWrite(REG_CMD, {24'h0, READ}, resp);
		if (irq !== 1'b0)
			reportMismatch("irq", irq, 1'b0);
		axiRead(REG_STAT, rd, resp);
		if (rd !== 32'h1)
			reportMismatch("STAT", rd, 32'h1);
		waitDone();
		if (irq !== 1'b1)
			reportMismatch("irq", irq, 1'b1);
		axiRead(REG_DATA, rd, resp);
		obs.adrs = 24'h00_0040;
		obs.got  = rd;
		obsQ.push_back(obs);
		axiWrite(REG_CTRL, 32'h0000_0001, resp);
		if (irq !== 1'b0)
			reportMismatch("irq", irq, 1'b0);
		finishTest("5 completion and interrupt");
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		rst         = 1'b1;
		s_awaddr    = 5'h0;
		s_awvalid   = 1'b0;
		s_wdata     = 32'h0;
		s_wstrb     = 4'h0;
		s_wvalid    = 1'b0;
		s_bready    = 1'b0;
		s_araddr    = 5'h0;
		s_arvalid   = 1'b0;
		s_rready    = 1'b0;
		lfsrState   = 32'hb4e5_ca65;
		cycleCnt    = 0;
		errCount    = 0;
		testErrBase = 0;
		testsRun    = 0;
		testsFailed = 0;
		repeat (16) @(posedge sysClk);
		#1;
		rst = 1'b0;
		testReset();
		testMemory();
		testDivider();
		testErrors();
		testIrq();
		errCount += dut.protoChk.failCnt;
		$display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
			testsRun, testsFailed, errCount, dut.protoChk.failCnt);
		if (errCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- build.f
src/psramPkg.sv
src/psramCkeGen.sv
src/psramSeqFsm.sv
src/psramShifter.sv
src/psramCsr.sv
src/psramUnit.sv
verif/psramModel.sv
verif/psramUnit_assertions.sv
verif/psramUnitTb.sv
